//--- hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	localparam int XLEN   = 32;
	localparam int STRB_W = XLEN / 8;
	localparam int EXC_W  = 6;

	// major opcodes
	localparam logic [6:0] OPC_LOAD  = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;

	// funct3 for loads and stores
	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

	// exception codes, one hot
	localparam logic [EXC_W-1:0] EXC_LD_FAULT    = 6'b000001;
	localparam logic [EXC_W-1:0] EXC_ST_FAULT    = 6'b000010;
	localparam logic [EXC_W-1:0] EXC_LD_MISALIGN = 6'b000100;
	localparam logic [EXC_W-1:0] EXC_ST_MISALIGN = 6'b001000;

	typedef enum logic [1:0] {
		SZ_BYTE = 2'd0,
		SZ_HALF = 2'd1,
		SZ_WORD = 2'd2
	} mem_size_e;

	// operation between agu and access stage
	typedef struct packed {
		logic [XLEN-1:0]   addr;
		logic [XLEN-1:0]   wdata;
		logic [STRB_W-1:0] strb;
		mem_size_e         size;
		logic              is_load;
		logic              is_signed;
		logic              misalign;
	} ls_op_t;

	// result of the access stage
	typedef struct packed {
		logic [XLEN-1:0]  addr;
		mem_size_e        size;
		logic             is_load;
		logic             is_signed;
		logic [XLEN-1:0]  rdata;
		logic [EXC_W-1:0] exc;
	} wb_op_t;

endpackage

`default_nettype wire

//--- hdl/lsu_agu.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_agu (
	input  wire                      opcode_valid_i,
	input  wire  [lsu_pkg::XLEN-1:0] opcode_opcode_i,
	input  wire  [lsu_pkg::XLEN-1:0] opcode_ra_operand_i,
	input  wire  [lsu_pkg::XLEN-1:0] opcode_rb_operand_i,
	output logic                     op_valid_o,
	output lsu_pkg::ls_op_t          op_o
);
	import lsu_pkg::*;

	logic [6:0]      opc;
	logic [2:0]      f3;
	logic            is_load;
	logic            is_store;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] addr;

	assign opc = opcode_opcode_i[6:0];
	assign f3  = opcode_opcode_i[14:12];

	// ******************** decode
	assign is_load  = (opc == OPC_LOAD) &&
		(f3 == F3_B || f3 == F3_H || f3 == F3_W || f3 == F3_BU || f3 == F3_HU);
	assign is_store = (opc == OPC_STORE) && (f3 == F3_B || f3 == F3_H || f3 == F3_W);

	assign op_valid_o = opcode_valid_i & (is_load | is_store);

	// ******************** address
	assign imm_i = {{20{opcode_opcode_i[31]}}, opcode_opcode_i[31:20]};
	assign imm_s = {{20{opcode_opcode_i[31]}}, opcode_opcode_i[31:25], opcode_opcode_i[11:7]};
	assign addr  = opcode_ra_operand_i + (is_store ? imm_s : imm_i);

	// ******************** lanes and misalignment
	always_comb begin
		op_o           = '0;
		op_o.addr      = addr;
		op_o.is_load   = is_load;
		op_o.is_signed = is_load & ~f3[2];
		case (f3[1:0])
			2'b00: begin
				op_o.size  = SZ_BYTE;
				op_o.wdata = {4{opcode_rb_operand_i[7:0]}};
				op_o.strb  = 4'b0001 << addr[1:0];
			end
			2'b01: begin
				op_o.size     = SZ_HALF;
				op_o.wdata    = {2{opcode_rb_operand_i[15:0]}};
				op_o.strb     = addr[1] ? 4'b1100 : 4'b0011;
				op_o.misalign = addr[0];
			end
			default: begin
				op_o.size     = SZ_WORD;
				op_o.wdata    = opcode_rb_operand_i;
				op_o.strb     = 4'b1111;
				op_o.misalign = |addr[1:0];
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/lsu_stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_stage_reg #(
	parameter type payload_t = logic
) (
	input  wire      clk_i,
	input  wire      rst_i,
	input  wire      load_i,
	input  wire      flush_i,
	input  wire      payload_t data_i,
	output logic     valid_o,
	output payload_t data_o
);

	// flush wins over load
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			valid_o <= 1'b0;
		end else if (flush_i) begin
			valid_o <= 1'b0;
		end else if (load_i) begin
			valid_o <= 1'b1;
		end
	end

	// payload only
	always_ff @(posedge clk_i) begin
		if (load_i) begin
			data_o <= data_i;
		end
	end

endmodule

`default_nettype wire

//--- hdl/lsu_apb_master.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_apb_master #(
	parameter int ADDR_W = 16
) (
	input  wire                        clk_i,
	input  wire                        rst_i,
	input  wire                        op_valid_i,
	input  wire  lsu_pkg::ls_op_t      op_i,
	input  wire                        flush_i,
	output logic                       ready_o,
	output logic                       done_o,
	output lsu_pkg::wb_op_t            wb_o,
	output logic                       psel_o,
	output logic                       penable_o,
	output logic                       pwrite_o,
	output logic [ADDR_W-1:0]          paddr_o,
	output logic [lsu_pkg::XLEN-1:0]   pwdata_o,
	output logic [lsu_pkg::STRB_W-1:0] pstrb_o,
	input  wire  [lsu_pkg::XLEN-1:0]   prdata_i,
	input  wire                        pready_i,
	input  wire                        pslverr_i
);
	import lsu_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS
	} state_e;

	state_e state_q;
	ls_op_t hold_q;
	logic   take;

	assign ready_o = (state_q == ST_IDLE);
	assign take    = ready_o & op_valid_i & ~flush_i;

	// ********************
	// a misaligned op sits in setup for one cycle without selecting the bus
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE:
					if (take) state_q <= ST_SETUP;
				ST_SETUP:
					if (flush_i || hold_q.misalign) state_q <= ST_IDLE;
					else state_q <= ST_ACCESS;
				ST_ACCESS:
					if (pready_i) state_q <= ST_IDLE;
				default:
					state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (take) begin
			hold_q <= op_i;
		end
	end

	// ******************** bus side
	assign psel_o    = (state_q == ST_ACCESS) ||
		(state_q == ST_SETUP && !hold_q.misalign && !flush_i);
	assign penable_o = (state_q == ST_ACCESS);
	assign pwrite_o  = ~hold_q.is_load;
	assign paddr_o   = hold_q.addr[ADDR_W-1:0];
	assign pwdata_o  = hold_q.wdata;
	// reads return the full word
	assign pstrb_o   = hold_q.is_load ? '0 : hold_q.strb;

	// ******************** result
	assign done_o = (state_q == ST_ACCESS && pready_i) ||
		(state_q == ST_SETUP && hold_q.misalign && !flush_i);

	always_comb begin
		wb_o.addr      = hold_q.addr;
		wb_o.size      = hold_q.size;
		wb_o.is_load   = hold_q.is_load;
		wb_o.is_signed = hold_q.is_signed;
		wb_o.rdata     = prdata_i;
		if (hold_q.misalign) begin
			wb_o.exc = hold_q.is_load ? EXC_LD_MISALIGN : EXC_ST_MISALIGN;
		end else if (state_q == ST_ACCESS && pslverr_i) begin
			wb_o.exc = hold_q.is_load ? EXC_LD_FAULT : EXC_ST_FAULT;
		end else begin
			wb_o.exc = '0;
		end
	end

	// setup is always followed by its access phase
	a_setup_then_access: assert property (
		@(posedge clk_i) disable iff (rst_i) (psel_o && !penable_o) |=> (psel_o && penable_o)
	);

	a_addr_stable: assert property (
		@(posedge clk_i) disable iff (rst_i) (psel_o && !pready_i) |=> $stable(paddr_o)
	);

endmodule

`default_nettype wire

//--- hdl/lsu_load_align.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_load_align (
	input  wire                        valid_i,
	input  wire  lsu_pkg::wb_op_t      wb_i,
	output logic                       writeback_valid_o,
	output logic [lsu_pkg::XLEN-1:0]   writeback_value_o,
	output logic [lsu_pkg::EXC_W-1:0]  writeback_exception_o
);
	import lsu_pkg::*;

	logic [7:0]      byte_sel;
	logic [15:0]     half_sel;
	logic [XLEN-1:0] load_val;

	// lane pick from low address bits
	assign byte_sel = wb_i.rdata[{wb_i.addr[1:0], 3'b000} +: 8];
	assign half_sel = wb_i.addr[1] ? wb_i.rdata[31:16] : wb_i.rdata[15:0];

	always_comb begin
		case (wb_i.size)
			SZ_BYTE: load_val = {{24{wb_i.is_signed & byte_sel[7]}}, byte_sel};
			SZ_HALF: load_val = {{16{wb_i.is_signed & half_sel[15]}}, half_sel};
			default: load_val = wb_i.rdata;
		endcase
	end

	assign writeback_valid_o     = valid_i;
	assign writeback_exception_o = valid_i ? wb_i.exc : '0;

	// faulting address goes back as the value
	always_comb begin
		if (|wb_i.exc) begin
			writeback_value_o = wb_i.addr;
		end else if (wb_i.is_load) begin
			writeback_value_o = load_val;
		end else begin
			writeback_value_o = '0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
	parameter int ADDR_W = 16
) (
	input  wire                        clk_i,
	input  wire                        rst_i,
	input  wire                        opcode_valid_i,
	input  wire  [lsu_pkg::XLEN-1:0]   opcode_opcode_i,
	input  wire  [lsu_pkg::XLEN-1:0]   opcode_ra_operand_i,
	input  wire  [lsu_pkg::XLEN-1:0]   opcode_rb_operand_i,
	output logic                       stall_o,
	output logic                       writeback_valid_o,
	output logic [lsu_pkg::XLEN-1:0]   writeback_value_o,
	output logic [lsu_pkg::EXC_W-1:0]  writeback_exception_o,
	output logic                       psel_o,
	output logic                       penable_o,
	output logic                       pwrite_o,
	output logic [ADDR_W-1:0]          paddr_o,
	output logic [lsu_pkg::XLEN-1:0]   pwdata_o,
	output logic [lsu_pkg::STRB_W-1:0] pstrb_o,
	input  wire  [lsu_pkg::XLEN-1:0]   prdata_i,
	input  wire                        pready_i,
	input  wire                        pslverr_i
);
	import lsu_pkg::*;

	logic   agu_valid;
	ls_op_t agu_op;
	logic   ls1_valid;
	ls_op_t ls1_op;
	logic   ls1_load;
	logic   ls1_flush;
	logic   acc_ready;
	logic   acc_done;
	wb_op_t acc_wb;
	logic   wb_valid;
	wb_op_t wb_op;
	logic   fault;

	// ******************** control
	// a fault in wb drops ls1 and anything accepted this cycle
	assign fault     = |writeback_exception_o;
	assign stall_o   = ls1_valid & ~acc_ready & ~fault;
	assign ls1_load  = agu_valid & ~stall_o & ~fault;
	assign ls1_flush = ~ls1_load & ~stall_o;

	lsu_agu u_agu (
		.opcode_valid_i      (opcode_valid_i),
		.opcode_opcode_i     (opcode_opcode_i),
		.opcode_ra_operand_i (opcode_ra_operand_i),
		.opcode_rb_operand_i (opcode_rb_operand_i),
		.op_valid_o          (agu_valid),
		.op_o                (agu_op)
	);

	lsu_stage_reg #(.payload_t(ls_op_t)) u_ls1 (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.load_i  (ls1_load),
		.flush_i (ls1_flush),
		.data_i  (agu_op),
		.valid_o (ls1_valid),
		.data_o  (ls1_op)
	);

	lsu_apb_master #(.ADDR_W(ADDR_W)) u_acc (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.op_valid_i (ls1_valid),
		.op_i       (ls1_op),
		.flush_i    (fault),
		.ready_o    (acc_ready),
		.done_o     (acc_done),
		.wb_o       (acc_wb),
		.psel_o     (psel_o),
		.penable_o  (penable_o),
		.pwrite_o   (pwrite_o),
		.paddr_o    (paddr_o),
		.pwdata_o   (pwdata_o),
		.pstrb_o    (pstrb_o),
		.prdata_i   (prdata_i),
		.pready_i   (pready_i),
		.pslverr_i  (pslverr_i)
	);

	// wb holds a result for exactly one cycle
	lsu_stage_reg #(.payload_t(wb_op_t)) u_wb (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.load_i  (acc_done),
		.flush_i (~acc_done),
		.data_i  (acc_wb),
		.valid_o (wb_valid),
		.data_o  (wb_op)
	);

	lsu_load_align u_align (
		.valid_i               (wb_valid),
		.wb_i                  (wb_op),
		.writeback_valid_o     (writeback_valid_o),
		.writeback_value_o     (writeback_value_o),
		.writeback_exception_o (writeback_exception_o)
	);

endmodule

`default_nettype wire

//--- tb/apb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module apb_mem_model #(
	parameter int ADDR_W = 16,
	parameter int DEPTH  = 1024
) (
	input  wire                        clk_i,
	input  wire                        rst_i,
	input  wire                        psel_i,
	input  wire                        penable_i,
	input  wire                        pwrite_i,
	input  wire  [ADDR_W-1:0]          paddr_i,
	input  wire  [lsu_pkg::XLEN-1:0]   pwdata_i,
	input  wire  [lsu_pkg::STRB_W-1:0] pstrb_i,
	output logic [lsu_pkg::XLEN-1:0]   prdata_o,
	output logic                       pready_o,
	output logic                       pslverr_o
);

	logic [31:0] mem [DEPTH];
	logic [1:0]  wait_q;
	logic [9:0]  idx;
	logic        err_win;
	logic        access;

	assign idx     = paddr_i[11:2];
	assign err_win = paddr_i[12];
	assign access  = psel_i & penable_i;

	// fill pattern from the word index
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h0bad_f00d;
		end
	end

	// ********************
	// wait states come from address bits [4:3]
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			wait_q <= '0;
		end else if (access && !pready_o) begin
			wait_q <= wait_q + 2'd1;
		end else begin
			wait_q <= '0;
		end
	end

	assign pready_o  = access && (wait_q == paddr_i[4:3]);
	assign pslverr_o = pready_o && err_win;
	assign prdata_o  = mem[idx];

	// writes land on the completing cycle, never inside the error window
	always @(posedge clk_i) begin
		if (pready_o && pwrite_i && !err_win) begin
			for (int b = 0; b < 4; b++) begin
				if (pstrb_i[b]) begin
					mem[idx][8*b +: 8] <= pwdata_i[8*b +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_lsu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lsu;
	import lsu_pkg::*;

	localparam int ADDR_W      = 16;
	localparam int CLK_PERIOD  = 40;
	localparam int NUM_OPS     = 400;
	localparam int WATCHDOG_NS = NUM_OPS * 12 * CLK_PERIOD;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic [2:0]  f3;
		logic        is_load;
	} exp_op_t;

	logic              clk;
	logic              rst;
	logic              opcode_valid;
	logic [31:0]       opcode;
	logic [31:0]       ra_operand;
	logic [31:0]       rb_operand;
	logic              stall;
	logic              wb_valid;
	logic [31:0]       wb_value;
	logic [EXC_W-1:0]  wb_exc;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [31:0]       pwdata;
	logic [3:0]        pstrb;
	logic [31:0]       prdata;
	logic              pready;
	logic              pslverr;

	logic [31:0] rng;
	exp_op_t     exp_q[$];
	logic        head_bus_seen;
	logic        fault_now;
	logic [31:0] shadow [1024];
	int          accepted;
	int          checked;
	int          mismatches;
	int          failures;

	lsu_top #(.ADDR_W(ADDR_W)) UUT (
		.clk_i                 (clk),
		.rst_i                 (rst),
		.opcode_valid_i        (opcode_valid),
		.opcode_opcode_i       (opcode),
		.opcode_ra_operand_i   (ra_operand),
		.opcode_rb_operand_i   (rb_operand),
		.stall_o               (stall),
		.writeback_valid_o     (wb_valid),
		.writeback_value_o     (wb_value),
		.writeback_exception_o (wb_exc),
		.psel_o                (psel),
		.penable_o             (penable),
		.pwrite_o              (pwrite),
		.paddr_o               (paddr),
		.pwdata_o              (pwdata),
		.pstrb_o               (pstrb),
		.prdata_i              (prdata),
		.pready_i              (pready),
		.pslverr_i             (pslverr)
	);

	apb_mem_model #(.ADDR_W(ADDR_W)) u_mem (
		.clk_i     (clk),
		.rst_i     (rst),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.pstrb_i   (pstrb),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr)
	);

	// ******************** helpers
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// byte b is enabled when the access covers it
	function automatic logic [3:0] lane_strobe(input logic [2:0] f3, input logic [1:0] a);
		int         nbytes;
		logic [3:0] s;
		nbytes = 1 << f3[1:0];
		s = '0;
		for (int b = 0; b < 4; b++) begin
			if (b >= int'(a) && b < int'(a) + nbytes) begin
				s[b] = 1'b1;
			end
		end
		return s;
	endfunction

	// store value repeated into every lane
	function automatic logic [31:0] lane_wdata(input logic [2:0] f3, input logic [31:0] v);
		logic [31:0] w;
		for (int b = 0; b < 4; b++) begin
			case (f3[1:0])
				2'b00:   w[8*b +: 8] = v[7:0];
				2'b01:   w[8*b +: 8] = v[8*(b%2) +: 8];
				default: w[8*b +: 8] = v[8*b +: 8];
			endcase
		end
		return w;
	endfunction

	function automatic logic [31:0] extract_load(input logic [2:0] f3, input logic [1:0] a,
		input logic [31:0] w);
		logic [31:0] sh;
		sh = w >> (8 * a);
		case (f3)
			F3_B:    return {{24{sh[7]}}, sh[7:0]};
			F3_BU:   return {24'h0, sh[7:0]};
			F3_H:    return {{16{sh[15]}}, sh[15:0]};
			F3_HU:   return {16'h0, sh[15:0]};
			default: return w;
		endcase
	endfunction

	function automatic logic misaligned(input logic [2:0] f3, input logic [1:0] a);
		return (f3[1:0] == 2'b01 && a[0]) || (f3[1:0] == 2'b10 && a != 2'b00);
	endfunction

	task automatic show_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, want);
		mismatches++;
	endtask

	task automatic flag_error(input string msg);
		$display("error at %0d ns: %s", $time, msg);
		failures++;
	endtask

	// ******************** checks, once per cycle at the falling edge
	task automatic check_cycle();
		exp_op_t     e;
		logic [9:0]  idx;
		logic [1:0]  a;
		logic [3:0]  strb;
		logic [31:0] wdata;
		logic [5:0]  exp_exc;
		logic [31:0] exp_val;
		fault_now = 1'b0;
		if (stall && exp_q.size() < 2) begin
			flag_error("stall_o high with no operation waiting behind a busy access stage");
		end
		if (wb_valid && exp_q.size() == 0) begin
			flag_error("writeback with no operation pending");
		end else if (wb_valid) begin
			e = exp_q.pop_front();
			a = e.addr[1:0];
			idx = e.addr[11:2];
			strb = lane_strobe(e.f3, a);
			wdata = lane_wdata(e.f3, e.data);
			exp_exc = '0;
			exp_val = '0;
			if (misaligned(e.f3, a)) begin
				exp_exc = e.is_load ? EXC_LD_MISALIGN : EXC_ST_MISALIGN;
				exp_val = e.addr;
				if (head_bus_seen) begin
					flag_error("misaligned operation reached the bus");
				end
			end else begin
				if (!head_bus_seen) begin
					flag_error("aligned operation wrote back without a bus transfer");
				end
				if (e.addr[12]) begin
					exp_exc = e.is_load ? EXC_LD_FAULT : EXC_ST_FAULT;
					exp_val = e.addr;
				end else if (e.is_load) begin
					exp_val = extract_load(e.f3, a, shadow[idx]);
				end else begin
					for (int b = 0; b < 4; b++) begin
						if (strb[b]) begin
							shadow[idx][8*b +: 8] = wdata[8*b +: 8];
						end
					end
				end
			end
			if (!e.is_load && u_mem.mem[idx] !== shadow[idx]) begin
				show_mismatch("memory word", u_mem.mem[idx], shadow[idx]);
			end
			if (wb_exc !== exp_exc) begin
				show_mismatch("writeback_exception_o", 32'(wb_exc), 32'(exp_exc));
			end
			if (wb_value !== exp_val) begin
				show_mismatch("writeback_value_o", wb_value, exp_val);
			end
			checked++;
			head_bus_seen = 1'b0;
			// a fault drops every younger operation, this cycle's too
			if (exp_exc != '0) begin
				fault_now = 1'b1;
				exp_q.delete();
			end
		end else if (wb_exc !== '0) begin
			show_mismatch("writeback_exception_o", 32'(wb_exc), 32'h0);
		end

		// bus side, always for the oldest pending operation
		if (psel && !penable) begin
			if (exp_q.size() == 0) begin
				flag_error("APB setup with no operation pending");
			end else begin
				e = exp_q[0];
				if (misaligned(e.f3, e.addr[1:0])) begin
					flag_error("APB setup for a misaligned operation");
				end else if (head_bus_seen) begin
					flag_error("second APB transfer for one operation");
				end
			end
		end
		if (psel && penable && pready && exp_q.size() != 0) begin
			e = exp_q[0];
			if (paddr !== e.addr[ADDR_W-1:0]) begin
				show_mismatch("paddr_o", 32'(paddr), 32'(e.addr[ADDR_W-1:0]));
			end
			if (pwrite !== !e.is_load) begin
				show_mismatch("pwrite_o", 32'(pwrite), 32'(!e.is_load));
			end
			strb = e.is_load ? 4'b0000 : lane_strobe(e.f3, e.addr[1:0]);
			if (pstrb !== strb) begin
				show_mismatch("pstrb_o", 32'(pstrb), 32'(strb));
			end
			if (!e.is_load && pwdata !== lane_wdata(e.f3, e.data)) begin
				show_mismatch("pwdata_o", pwdata, lane_wdata(e.f3, e.data));
			end
			head_bus_seen = 1'b1;
		end
	endtask

	// ******************** stimulus
	task automatic drive_op();
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [31:0] base;
		logic [11:0] imm;
		logic [2:0]  f3;
		logic        is_load;
		exp_op_t     e;
		rng = xorshift32(rng);
		r1 = rng;
		rng = xorshift32(rng);
		r2 = rng;
		rng = xorshift32(rng);
		r3 = rng;
		opcode_valid = (r1[1:0] != 2'b00);
		if (!opcode_valid) begin
			// junk while valid is low
			opcode = r3;
			return;
		end
		accepted++;
		if (r1[5:2] == 4'h0) begin
			// 64-bit load or an ALU op, neither handled here
			opcode = r1[6] ? {r3[31:15], 3'b011, r3[11:7], OPC_LOAD} : {r3[31:7], 7'b0010011};
			return;
		end
		is_load = r1[6];
		if (is_load) begin
			case (32'(r1[10:7]) % 5)
				0:       f3 = F3_B;
				1:       f3 = F3_H;
				2:       f3 = F3_W;
				3:       f3 = F3_BU;
				default: f3 = F3_HU;
			endcase
		end else begin
			case (32'(r1[10:7]) % 3)
				0:       f3 = F3_B;
				1:       f3 = F3_H;
				default: f3 = F3_W;
			endcase
		end
		base = 32'h100 + {21'b0, r2[10:2], 2'b00};
		if (r1[16:14] == 3'b000) begin
			base = base | 32'h1000;
		end
		imm = {{5{r2[22]}}, r2[22:16]};
		// most accesses naturally aligned
		if (r1[13:11] != 3'b000) begin
			if (f3[1:0] == 2'b10) begin
				imm[1:0] = 2'b00;
			end else if (f3[1:0] == 2'b01) begin
				imm[0] = 1'b0;
			end
		end
		ra_operand = base;
		rb_operand = r3;
		if (is_load) begin
			opcode = {imm, r1[26:22], f3, r1[31:27], OPC_LOAD};
		end else begin
			opcode = {imm[11:5], r1[21:17], r1[26:22], f3, imm[4:0], OPC_STORE};
		end
		if (!fault_now) begin
			e.addr = base + {{20{imm[11]}}, imm};
			e.data = r3;
			e.f3 = f3;
			e.is_load = is_load;
			exp_q.push_back(e);
		end
	endtask

	task automatic run_cycle(input logic active);
		@(negedge clk);
		check_cycle();
		// inputs held while stalled
		if (!stall) begin
			if (active) begin
				drive_op();
			end else begin
				opcode_valid = 1'b0;
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		opcode_valid = 1'b0;
		opcode = '0;
		ra_operand = '0;
		rb_operand = '0;
		rng = 32'h3604;
		head_bus_seen = 1'b0;
		fault_now = 1'b0;
		accepted = 0;
		checked = 0;
		mismatches = 0;
		failures = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		if (stall || wb_valid || psel || penable) begin
			flag_error("outputs active during reset");
		end
		rst = 1'b0;
		for (int i = 0; i < 1024; i++) begin
			shadow[i] = u_mem.mem[i];
		end
		while (accepted < NUM_OPS) begin
			run_cycle(1'b1);
		end
		while (exp_q.size() != 0) begin
			run_cycle(1'b0);
		end
		repeat (10) run_cycle(1'b0);
		$display("%0d writebacks checked, %0d mismatches, %0d other errors",
			checked, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
hdl/lsu_pkg.sv
hdl/lsu_agu.sv
hdl/lsu_stage_reg.sv
hdl/lsu_apb_master.sv
hdl/lsu_load_align.sv
hdl/lsu_top.sv
tb/apb_mem_model.sv
tb/tb_lsu.sv

//--- run.sh
#!/bin/sh
# build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_lsu -f filelist.f --Mdir obj_dir -o tb_lsu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tb_lsu_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1
